//--- alu_settings.svh
/*
 * Sizing constants for the triadic ALU and its operand block.
 * Include this header wherever a width or a pipeline depth is needed;
 * the guard keeps repeated includes harmless.
 */

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Width of every data word: operands A, B, R, S and both results
`define ALU_WORD_WIDTH 32

// Clock edges from issuing an op to its Ra/Rb appearing at the outputs
// The operand block also uses this to line up a pending S load with Rb
`define ALU_LATENCY 4

// Register stages placed after the add/sub so that retiming can split
// the carry chain, must stay in step with the triadic path (two stages)
`define ALU_SUM_DELAY 2

`endif

//--- alu_data_pkg.sv
/*
 * Data-path types for the triadic ALU: the word type and the small
 * selector codes for the third operand and the output shift.
 * Import wherever words or selector codes are handled.
 */

`default_nettype none

`include "alu_settings.svh"

package alu_data_pkg;

    // One data word
    typedef logic [`ALU_WORD_WIDTH-1:0] alu_word_t;

    // --------------------------------------------------
    // Third operand selector
    typedef logic [1:0] r_sel_t;

    // Previous result as is
    localparam r_sel_t R_SEL_R         = 2'd0;
    // All ones when R is zero, else all zeros
    localparam r_sel_t R_SEL_ZERO_MASK = 2'd1;
    // R's sign bit copied to every bit
    localparam r_sel_t R_SEL_NEG_MASK  = 2'd2;
    // Persistent S register
    localparam r_sel_t R_SEL_S         = 2'd3;

    // --------------------------------------------------
    // Shift applied to the extended result
    typedef logic [1:0] shift_sel_t;

    localparam shift_sel_t SHIFT_NONE    = 2'd0;
    localparam shift_sel_t SHIFT_RIGHT_U = 2'd1;
    localparam shift_sel_t SHIFT_RIGHT_S = 2'd2;
    localparam shift_sel_t SHIFT_LEFT    = 2'd3;

endpackage

`default_nettype wire

//--- alu_ctrl_pkg.sv
/*
 * Control-side types for the triadic ALU: the dyadic truth table and the
 * packed 20-bit control word issued with every op.
 * Import together with the data package, whose selector codes it uses.
 */

`default_nettype none

package alu_ctrl_pkg;

    import alu_data_pkg::*;

    // Four-entry truth table of a two-input Boolean function
    // Result bit is table[{a_bit, b_bit}], so a selects the upper half
    typedef logic [3:0] truth_table_t;

    // --------------------------------------------------
    // Control word, most significant field first
    // Total width is 20 bits, matching the issue bus of the ALU
    typedef struct packed {
        // Ra takes the plain triadic result instead of the extended one
        logic         split;
        // Shift of the extended result, applied in the last stage
        shift_sel_t   shift;
        // Combines the second triadic result with the sum
        truth_table_t dyadic_3;
        // Sign controls of the add/sub path
        logic         negate_b;
        logic         negate_a;
        // Second mux uses the inverted mask, giving the complement result
        logic         triadic_dual;
        // Functions of A and B chosen between by the third operand
        truth_table_t dyadic_2;
        truth_table_t dyadic_1;
        // Which third operand steers the bitwise muxes
        r_sel_t       r_sel;
    } alu_ctrl_t;

endpackage

`default_nettype wire

//--- dyadic_op.sv
/*
 * Universal bitwise Boolean function of two words.
 * A 4-bit truth table picks any of the 16 two-input functions,
 * applied independently at every bit position. Purely combinational.
 */

`timescale 1ns/1ns
`default_nettype none

module dyadic_op
    import alu_data_pkg::*, alu_ctrl_pkg::*;
(
    input  wire truth_table_t op_table,
    input  wire alu_word_t    a,
    input  wire alu_word_t    b,
    output alu_word_t         o
);

    // Each output bit looks up its own pair of input bits in the table
    always_comb begin
        for (int i = 0; i < $bits(alu_word_t); i++) begin
            o[i] = op_table[{a[i], b[i]}];
        end
    end

endmodule

`default_nettype wire

//--- signed_add_sub.sv
/*
 * Computes +/-A +/-B modulo the word width.
 * The sum is followed by a short register chain so it leaves in step with
 * the triadic path, and so a retiming tool can push those registers back
 * into the carry chain.
 */

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module signed_add_sub
    import alu_data_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      arst_n,
    input  wire alu_word_t a,
    input  wire alu_word_t b,
    input  wire logic      negate_a,
    input  wire logic      negate_b,
    output alu_word_t      sum
);

    localparam int DELAY = `ALU_SUM_DELAY;

    alu_word_t a_term;
    alu_word_t b_term;
    alu_word_t sum_raw;
    alu_word_t sum_pipe [DELAY];

    // Two's complement negation, carry out of the top is dropped
    always_comb begin
        a_term  = negate_a ? -a : a;
        b_term  = negate_b ? -b : b;
        sum_raw = a_term + b_term;
    end

    // --------------------------------------------------
    // Delay chain, stage 0 takes the raw sum
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DELAY; i++) begin
                sum_pipe[i] <= '0;
            end
        end else begin
            sum_pipe[0] <= sum_raw;
            for (int i = 1; i < DELAY; i++) begin
                sum_pipe[i] <= sum_pipe[i-1];
            end
        end
    end

    assign sum = sum_pipe[DELAY-1];

endmodule

`default_nettype wire

//--- triadic_alu.sv
/*
 * Four-stage pipelined triadic Boolean ALU.
 * Every cycle it accepts a control word plus A and B, and returns Ra and Rb
 * four edges later. The third operand comes from R, two masks built from R,
 * or the persistent S. One op issues per cycle with no stalls.
 */

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module triadic_alu
    import alu_data_pkg::*, alu_ctrl_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      arst_n,
    input  wire alu_ctrl_t ctrl,
    input  wire alu_word_t a,
    input  wire alu_word_t b,
    input  wire alu_word_t r,
    input  wire alu_word_t s,
    output alu_word_t      ra,
    output alu_word_t      rb
);

    localparam int STAGES = `ALU_LATENCY;

    // --------------------------------------------------
    // Control pipeline
    // Stage 0 reads the incoming word directly, later stages read a copy
    // registered alongside the data so each field is used where it belongs
    alu_ctrl_t ctrl_q [1:STAGES-1];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < STAGES; i++) begin
                ctrl_q[i] <= '0;
            end
        end else begin
            ctrl_q[1] <= ctrl;
            for (int i = 2; i < STAGES; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    // --------------------------------------------------
    // Stage 0: pick the third operand, evaluate d1 and d2, start the sum
    alu_word_t sel_raw;
    alu_word_t d1_raw;
    alu_word_t d2_raw;
    alu_word_t sel_q;
    alu_word_t d1_q;
    alu_word_t d2_q;
    alu_word_t sum;

    always_comb begin
        case (ctrl.r_sel)
            R_SEL_ZERO_MASK: sel_raw = {`ALU_WORD_WIDTH{~|r}};
            R_SEL_NEG_MASK:  sel_raw = {`ALU_WORD_WIDTH{r[`ALU_WORD_WIDTH-1]}};
            R_SEL_S:         sel_raw = s;
            default:         sel_raw = r;
        endcase
    end

    dyadic_op d1 (
        .op_table (ctrl.dyadic_1),
        .a        (a),
        .b        (b),
        .o        (d1_raw)
    );

    dyadic_op d2 (
        .op_table (ctrl.dyadic_2),
        .a        (a),
        .b        (b),
        .o        (d2_raw)
    );

    // The sum lands two edges later, right when stage 2 needs it
    signed_add_sub u_add_sub (
        .clock    (clock),
        .arst_n   (arst_n),
        .a        (a),
        .b        (b),
        .negate_a (ctrl.negate_a),
        .negate_b (ctrl.negate_b),
        .sum      (sum)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= '0;
            d1_q  <= '0;
            d2_q  <= '0;
        end else begin
            sel_q <= sel_raw;
            d1_q  <= d1_raw;
            d2_q  <= d2_raw;
        end
    end

    // --------------------------------------------------
    // Stage 1: bitwise muxes form the triadic result
    // A one in the mask takes d2, a zero takes d1
    // In dual mode the second mux sees the inverted mask, so the two
    // results are complementary selections of the same pair
    alu_word_t mask_2;
    alu_word_t sd1_q;
    alu_word_t sd2_q;

    assign mask_2 = ctrl_q[1].triadic_dual ? ~sel_q : sel_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sd1_q <= '0;
            sd2_q <= '0;
        end else begin
            sd1_q <= (d2_q & sel_q) | (d1_q & ~sel_q);
            sd2_q <= (d2_q & mask_2) | (d1_q & ~mask_2);
        end
    end

    // --------------------------------------------------
    // Stage 2: fold the sum into the second triadic result
    // The first result just moves along for a possible split
    alu_word_t d3_raw;
    alu_word_t d3_q;
    alu_word_t sd1_d;

    dyadic_op d3 (
        .op_table (ctrl_q[2].dyadic_3),
        .a        (sd2_q),
        .b        (sum),
        .o        (d3_raw)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            d3_q  <= '0;
            sd1_d <= '0;
        end else begin
            d3_q  <= d3_raw;
            sd1_d <= sd1_q;
        end
    end

    // --------------------------------------------------
    // Stage 3: shift by one place, then split
    alu_word_t shifted;

    always_comb begin
        case (ctrl_q[3].shift)
            SHIFT_RIGHT_U: shifted = d3_q >> 1;
            // Arithmetic shift keeps the sign bit
            SHIFT_RIGHT_S: shifted = alu_word_t'($signed(d3_q) >>> 1);
            // Top bit falls off
            SHIFT_LEFT:    shifted = d3_q << 1;
            default:       shifted = d3_q;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ra <= '0;
            rb <= '0;
        end else begin
            rb <= shifted;
            ra <= ctrl_q[3].split ? sd1_d : shifted;
        end
    end

    // --------------------------------------------------
    // The control word feeds every stage, so an X here spreads everywhere
    a_ctrl_known : assert property (
        @(posedge clock) disable iff (!arst_n) !$isunknown(ctrl)
    );

endmodule

`default_nettype wire

//--- operand_regs.sv
/*
 * Holds the persistent S operand next to the ALU.
 * S can be preset from outside at the next edge, or loaded from Rb once
 * the op that asked for the load has completed. A preset beats a load
 * arriving on the same edge.
 */

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module operand_regs
    import alu_data_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      arst_n,
    input  wire logic      s_load,
    input  wire logic      s_preset,
    input  wire alu_word_t s_preset_value,
    input  wire alu_word_t rb,
    output alu_word_t      s
);

    localparam int DEPTH = `ALU_LATENCY;

    // Load requests travel alongside their op through the ALU
    // The oldest bit is set exactly when that op's Rb is at the output
    logic [DEPTH-1:0] load_pipe;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            load_pipe <= '0;
        end else begin
            load_pipe <= {load_pipe[DEPTH-2:0], s_load};
        end
    end

    // --------------------------------------------------
    // S itself, preset checked first so it wins any collision
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s <= '0;
        end else if (s_preset) begin
            s <= s_preset_value;
        end else if (load_pipe[DEPTH-1]) begin
            s <= rb;
        end
    end

    // --------------------------------------------------
    // An unknown preset strobe would leave S undefined
    a_preset_known : assert property (
        @(posedge clock) disable iff (!arst_n) !$isunknown(s_preset)
    );

endmodule

`default_nettype wire

//--- alu_subsystem.sv
/*
 * Top level of the ALU block.
 * Joins the triadic ALU with the S operand register and feeds Ra back
 * as the ALU's R operand. All inputs are sampled every rising edge.
 */

`timescale 1ns/1ns
`default_nettype none

module alu_subsystem
    import alu_data_pkg::*, alu_ctrl_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      arst_n,
    input  wire alu_ctrl_t ctrl,
    input  wire alu_word_t a,
    input  wire alu_word_t b,
    input  wire logic      s_load,
    input  wire logic      s_preset,
    input  wire alu_word_t s_preset_value,
    output alu_word_t      ra,
    output alu_word_t      rb
);

    // Persistent operand from the register block
    alu_word_t s;

    // R is simply the last Ra, looped straight back
    triadic_alu u_triadic_alu (
        .clock  (clock),
        .arst_n (arst_n),
        .ctrl   (ctrl),
        .a      (a),
        .b      (b),
        .r      (ra),
        .s      (s),
        .ra     (ra),
        .rb     (rb)
    );

    // S loads come from Rb, never from Ra
    operand_regs u_operand_regs (
        .clock          (clock),
        .arst_n         (arst_n),
        .s_load         (s_load),
        .s_preset       (s_preset),
        .s_preset_value (s_preset_value),
        .rb             (rb),
        .s              (s)
    );

endmodule

`default_nettype wire

//--- tb_alu_subsystem.sv
/*
 * Testbench for the ALU subsystem.
 * Issues seeded random ops in phases and checks Ra and Rb against a
 * reference model of the triadic ALU and its S register, four edges on.
 */

`timescale 1ns/1ns
`default_nettype none

`include "alu_settings.svh"

module tb_alu_subsystem
    import alu_data_pkg::*, alu_ctrl_pkg::*;
();

    localparam int W              = `ALU_WORD_WIDTH;
    localparam int RESET_CYCLES   = 10;
    localparam int TOTAL_OPS      = 2000;
    localparam int DRAIN_OPS      = `ALU_LATENCY;
    // Half again the expected run length
    localparam int TIMEOUT_CYCLES = (RESET_CYCLES + TOTAL_OPS + DRAIN_OPS) * 3 / 2;

    // Expected outputs of one op
    typedef struct packed {
        alu_word_t ra;
        alu_word_t rb;
    } result_pair_t;

    logic      clock;
    logic      arst_n;
    alu_ctrl_t ctrl;
    alu_word_t a;
    alu_word_t b;
    logic      s_load;
    logic      s_preset;
    alu_word_t s_preset_value;
    alu_word_t ra;
    alu_word_t rb;

    integer seed;
    int     cycle_count;

    // --------------------------------------------------
    // Reference model state
    // The front of expect_q is the op whose result appears at this edge
    result_pair_t expect_q [$];
    logic         load_q [$];
    alu_word_t    model_r;
    alu_word_t    model_s;
    alu_word_t    last_rb;

    alu_subsystem u_alu_subsystem (
        .clock          (clock),
        .arst_n         (arst_n),
        .ctrl           (ctrl),
        .a              (a),
        .b              (b),
        .s_load         (s_load),
        .s_preset       (s_preset),
        .s_preset_value (s_preset_value),
        .ra             (ra),
        .rb             (rb)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Ends a run that never reaches its last phase
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation timed out");
    end

    task automatic check_value(string name, alu_word_t got, alu_word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // Sum of products over the four table entries
    function automatic alu_word_t apply_table(truth_table_t t, alu_word_t x, alu_word_t y);
        return ({W{t[3]}} & x & y) | ({W{t[2]}} & x & ~y)
             | ({W{t[1]}} & ~x & y) | ({W{t[0]}} & ~x & ~y);
    endfunction

    function automatic result_pair_t predict(alu_ctrl_t c, alu_word_t x, alu_word_t y,
                                             alu_word_t r, alu_word_t s);
        alu_word_t    m;
        alu_word_t    m2;
        alu_word_t    t1;
        alu_word_t    t2;
        alu_word_t    sx;
        alu_word_t    sy;
        alu_word_t    ext;
        alu_word_t    sh;
        result_pair_t res;
        case (c.r_sel)
            R_SEL_R:         m = r;
            R_SEL_ZERO_MASK: m = (r == '0) ? '1 : '0;
            R_SEL_NEG_MASK:  m = r[W-1] ? '1 : '0;
            default:         m = s;
        endcase
        m2  = c.triadic_dual ? ~m : m;
        // Mask bit one picks the second function, zero the first
        t1  = (apply_table(c.dyadic_1, x, y) & ~m) | (apply_table(c.dyadic_2, x, y) & m);
        t2  = (apply_table(c.dyadic_1, x, y) & ~m2) | (apply_table(c.dyadic_2, x, y) & m2);
        sx  = c.negate_a ? (~x + alu_word_t'(1)) : x;
        sy  = c.negate_b ? (~y + alu_word_t'(1)) : y;
        ext = apply_table(c.dyadic_3, t2, sx + sy);
        case (c.shift)
            SHIFT_RIGHT_U: sh = {1'b0, ext[W-1:1]};
            SHIFT_RIGHT_S: sh = {ext[W-1], ext[W-1:1]};
            SHIFT_LEFT:    sh = {ext[W-2:0], 1'b0};
            default:       sh = ext;
        endcase
        res.rb = sh;
        res.ra = c.split ? t1 : sh;
        return res;
    endfunction

    // --------------------------------------------------
    // One rising edge of the model, called 1 ns after the edge while the
    // inputs the DUT just sampled are still applied
    task automatic model_edge();
        result_pair_t pred;
        result_pair_t done;
        logic         load_due;
        pred = predict(ctrl, a, b, model_r, model_s);
        expect_q.push_back(pred);
        // The load of the op issued four edges ago takes that op's Rb
        load_due = load_q.pop_front();
        load_q.push_back(s_load);
        if (s_preset) begin
            model_s = s_preset_value;
        end else if (load_due) begin
            model_s = last_rb;
        end
        done = expect_q.pop_front();
        check_value("ra", ra, done.ra);
        check_value("rb", rb, done.rb);
        // Ra now on the outputs is the R of the next issued op
        model_r = done.ra;
        last_rb = done.rb;
    endtask

    function automatic alu_word_t rand_word();
        logic [31:0] v;
        v = $random(seed);
        return alu_word_t'(v);
    endfunction

    function automatic alu_ctrl_t rand_ctrl();
        logic [31:0] v;
        v = $random(seed);
        return alu_ctrl_t'(v[$bits(alu_ctrl_t)-1:0]);
    endfunction

    task automatic issue_op(alu_ctrl_t c, alu_word_t x, alu_word_t y,
                            logic load, logic preset, alu_word_t pval);
        ctrl           = c;
        a              = x;
        b              = y;
        s_load         = load;
        s_preset       = preset;
        s_preset_value = pval;
        @(posedge clock);
        #1;
        model_edge();
    endtask

    // --------------------------------------------------
    // Test phases
    task automatic check_after_reset();
        alu_ctrl_t c;
        check_value("ra", ra, '0);
        check_value("rb", rb, '0);
        // Mask through d2, zero through d1, then pass the second mux out
        c          = '0;
        c.r_sel    = R_SEL_S;
        c.dyadic_1 = 4'b0000;
        c.dyadic_2 = 4'b1111;
        c.dyadic_3 = 4'b1100;
        issue_op(c, rand_word(), rand_word(), 1'b0, 1'b0, '0);
        repeat (3) issue_op('0, '0, '0, 1'b0, 1'b0, '0);
        check_value("ra", ra, '0);
    endtask

    task automatic random_unsplit_ops(int count);
        alu_ctrl_t c;
        for (int i = 0; i < count; i++) begin
            c       = rand_ctrl();
            c.split = 1'b0;
            issue_op(c, rand_word(), rand_word(), 1'b0, 1'b0, '0);
        end
    endtask

    task automatic split_dual_ops(int count);
        alu_ctrl_t c;
        for (int i = 0; i < count; i++) begin
            c       = rand_ctrl();
            c.split = 1'b1;
            // Every other op shows the second mux directly on Rb
            if (i % 2 == 0) begin
                c.dyadic_3 = 4'b1100;
                c.shift    = SHIFT_NONE;
            end
            issue_op(c, rand_word(), rand_word(), 1'b0, 1'b0, '0);
        end
    endtask

    task automatic shift_ops(int count);
        alu_ctrl_t c;
        for (int i = 0; i < count; i++) begin
            c       = rand_ctrl();
            c.shift = shift_sel_t'(i % 4);
            // Half the ops shift the plain sum, which often has its sign set
            if (i % 8 < 4) begin
                c.dyadic_3 = 4'b1010;
            end
            issue_op(c, rand_word(), rand_word(), 1'b0, 1'b0, '0);
        end
    endtask

    task automatic feedback_mask_ops(int count);
        alu_ctrl_t c;
        alu_word_t pick;
        for (int i = 0; i < count; i++) begin
            c       = rand_ctrl();
            pick    = rand_word();
            c.r_sel = pick[2] ? R_SEL_NEG_MASK : R_SEL_ZERO_MASK;
            case (pick[1:0])
                // Forces a zero result
                2'd0: begin
                    c.split    = 1'b0;
                    c.dyadic_3 = 4'b0000;
                end
                // Forces an all-ones, negative result
                2'd1: begin
                    c.split    = 1'b0;
                    c.shift    = SHIFT_NONE;
                    c.dyadic_3 = 4'b1111;
                end
                default: ;
            endcase
            issue_op(c, rand_word(), rand_word(), 1'b0, 1'b0, '0);
        end
    endtask

    task automatic s_register_ops(int count);
        alu_ctrl_t c;
        alu_word_t pick;
        // A preset arriving on the same edge as a delayed load
        for (int k = 0; k < 4; k++) begin
            c       = rand_ctrl();
            c.r_sel = R_SEL_S;
            issue_op(c, rand_word(), rand_word(), 1'b1, 1'b0, '0);
            repeat (3) issue_op(c, rand_word(), rand_word(), 1'b0, 1'b0, '0);
            issue_op(c, rand_word(), rand_word(), 1'b0, 1'b1, rand_word());
        end
        for (int i = 0; i < count - 20; i++) begin
            c    = rand_ctrl();
            pick = rand_word();
            if (pick[6:5] != 2'd0) begin
                c.r_sel = R_SEL_S;
            end
            issue_op(c, rand_word(), rand_word(), pick[1:0] == 2'd0,
                     pick[4:2] == 3'd0, rand_word());
        end
    endtask

    // --------------------------------------------------
    initial begin
        seed           = 69283;
        arst_n         = 1'b0;
        ctrl           = '0;
        a              = '0;
        b              = '0;
        s_load         = 1'b0;
        s_preset       = 1'b0;
        s_preset_value = '0;
        model_r        = '0;
        model_s        = '0;
        last_rb        = '0;
        // Ops before reset release behave as all-zero ops
        repeat (`ALU_LATENCY - 1) expect_q.push_back('0);
        repeat (`ALU_LATENCY) load_q.push_back(1'b0);
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        arst_n = 1'b1;

        check_after_reset();
        random_unsplit_ops(500);
        split_dual_ops(400);
        shift_ops(400);
        feedback_mask_ops(400);
        s_register_ops(TOTAL_OPS - 1704);
        repeat (DRAIN_OPS) issue_op('0, '0, '0, 1'b0, 1'b0, '0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
alu_data_pkg.sv
alu_ctrl_pkg.sv
dyadic_op.sv
signed_add_sub.sv
triadic_alu.sv
operand_regs.sv
alu_subsystem.sv
tb_alu_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the ALU testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sim.f \
    --top-module tb_alu_subsystem \
    -o sim_alu_subsystem
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_alu_subsystem
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
